//--- Bender.yml
package:
  name: fir_filter

sources:
  # Packages come first, then the datapath and the top level.
  - files:
      - hdl/firTypesPkg.sv
      - hdl/firCtrlPkg.sv
      - hdl/coeffRom.sv
      - hdl/tapLine.sv
      - hdl/macSum.sv
      - hdl/firControl.sv
      - hdl/firFilter.sv
  # Testbench, with its helper header on the include path.
  - target: test
    include_dirs:
      - bench
    files:
      - bench/firFilterTb.sv

//--- bench/firTbUtil.svh
`ifndef FIR_TB_UTIL_SVH
`define FIR_TB_UTIL_SVH

// Helpers for firFilterTb, included into the body of the testbench module.
// They use LENGTH, DATA_WIDTH and ACC_WIDTH of the enclosing module.

// State of the xorshift generator.
logic [31:0] rngState = 32'h44ccf79f;

// Accepted samples, newest on entry 0, as the DUT sample line should hold them.
logic signed [DATA_WIDTH-1:0] history [0:LENGTH-1];

// One xorshift32 step.
function automatic logic [31:0] xorshiftStep(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// Advances the generator and hands back the new word.
function automatic logic [31:0] randomWord();
	rngState = xorshiftStep(rngState);
	return rngState;
endfunction

// Empties the model history, as Idle empties the DUT sample line.
task automatic clearHistory();
	for (int n = 0; n < LENGTH; n++) begin
		history[n] = '0;
	end
endtask

// Takes one accepted sample into the model history.
task automatic pushSample(input logic signed [DATA_WIDTH-1:0] sample);
	for (int n = LENGTH - 1; n > 0; n--) begin
		history[n] = history[n-1];
	end
	history[0] = sample;
endtask

// Direct convolution y[k] as the sum of h[n] * x[k-n] over the history.
// Missing history is zero, because the history starts out cleared.
function automatic logic signed [ACC_WIDTH-1:0] modelOutput();
	longint acc;
	acc = 0;
	for (int n = 0; n < LENGTH; n++) begin
		acc += longint'(firTypesPkg::COEFF_TABLE[n]) * longint'(history[n]);
	end
	return ACC_WIDTH'(acc);
endfunction

`endif

//--- bench/firFilterTb.sv
`timescale 1ns/10ps
`default_nettype none

// Testbench for firFilter in its default 20-tap, 8-bit configuration.
// Concurrent assertions watch the strobe, ready and valid protocol.
// Immediate assertions compare each result with a convolution model.
module firFilterTb;

	localparam int LENGTH = 20;
	localparam int DATA_WIDTH = 8;
	localparam int ACC_WIDTH = firTypesPkg::accWidth(DATA_WIDTH, LENGTH);

	logic clock;
	logic rst;
	logic loadData;
	logic stopLoad;
	logic signed [DATA_WIDTH-1:0] dataIn;
	logic ready;
	logic outValid;
	logic signed [ACC_WIDTH-1:0] dataOut;

	// Expected results, oldest first, one per accepted sample.
	logic signed [ACC_WIDTH-1:0] expectQ [$];
	logic signed [ACC_WIDTH-1:0] expected;

	`include "firTbUtil.svh"

	firFilter u_dut (
		.clock    (clock),
		.rst      (rst),
		.loadData (loadData),
		.stopLoad (stopLoad),
		.dataIn   (dataIn),
		.ready    (ready),
		.outValid (outValid),
		.dataOut  (dataOut)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic failValue(input string name, input logic [63:0] want, input logic [63:0] got);
		failRun($sformatf("[ERROR] %s expected 0x%0h actual 0x%0h", name, want, got));
	endtask

	// A sample seen with ready high gives exactly one outValid two edges later.
	validAfterSample: assert property (@(posedge clock) disable iff (rst)
		(loadData && ready) |-> ##2 outValid)
		else failRun("[ERROR] an accepted sample gave no outValid");

	// Every outValid traces back to an accepted sample, so strobes outside Run are ignored.
	validNeedsSample: assert property (@(posedge clock) disable iff (rst)
		outValid |-> $past(loadData && ready, 2))
		else failRun("[ERROR] outValid came without an accepted sample");

	// The result holds between valids.
	holdBetweenValids: assert property (@(posedge clock) disable iff (rst)
		!outValid |-> $stable(dataOut))
		else failRun("[ERROR] dataOut changed while outValid was low");

	stopDropsReady: assert property (@(posedge clock) disable iff (rst)
		(stopLoad && ready) |=> !ready)
		else failRun("[ERROR] ready stayed high after a stop strobe");

	// Outputs are compared at the falling edge, half a cycle after they settle.
	always @(negedge clock) begin
		if (!rst && outValid) begin
			assert (expectQ.size() > 0)
				else failRun("[ERROR] outValid with no accepted sample pending");
			expected = expectQ.pop_front();
			assert (dataOut == expected)
				else failValue("dataOut", expected, dataOut);
		end
	end

	// Drives one cycle of strobes and data, then steps to 1 ns after the next edge.
	// The level of ready seen now is the level that the sampling edge sees.
	task automatic driveCycle(
		input logic load,
		input logic stop,
		input logic signed [DATA_WIDTH-1:0] sample
	);
		loadData = load;
		stopLoad = stop;
		dataIn = sample;
		if (load && ready) begin
			pushSample(sample);
			expectQ.push_back(modelOutput());
		end
		// A stop sends the DUT through Idle, which empties its sample line.
		if (stop && ready) begin
			clearHistory();
		end
		@(posedge clock);
		#1;
		loadData = 1'b0;
		stopLoad = 1'b0;
	endtask

	// Random sample that hits both extremes about one time in eight.
	function automatic logic signed [DATA_WIDTH-1:0] randomSample();
		logic [31:0] r;
		r = randomWord();
		case (r[3:0])
			4'd0: return {1'b1, {(DATA_WIDTH-1){1'b0}}};
			4'd1: return {1'b0, {(DATA_WIDTH-1){1'b1}}};
			default: return r[8 +: DATA_WIDTH];
		endcase
	endfunction

	// Waits for ready and checks how many edges it took.
	// Random strobes keep coming meanwhile, and none of them may be filtered.
	task automatic expectReadyAfter(input int edges);
		int count;
		logic [31:0] r;
		count = 0;
		while (!ready && count < 4 * LENGTH) begin
			r = randomWord();
			loadData = r[0];
			dataIn = r[8 +: DATA_WIDTH];
			@(posedge clock);
			#1;
			count++;
		end
		loadData = 1'b0;
		if (!ready) begin
			failRun($sformatf("[ERROR] ready did not rise within %0d cycles", count));
		end else begin
			assert (count == edges) else failValue("readyDelay", edges, count);
		end
	endtask

	// Unit impulse into an empty history, then zeros.
	// The model must list the table from entry 0 upwards, and the DUT must match it.
	task automatic runImpulse();
		for (int i = 0; i < LENGTH; i++) begin
			driveCycle(1'b1, 1'b0, DATA_WIDTH'(i == 0));
			assert (expectQ[$] == ACC_WIDTH'(firTypesPkg::COEFF_TABLE[i]))
				else failValue("impulseModel", firTypesPkg::COEFF_TABLE[i], expectQ[$]);
		end
	endtask

	task automatic runRandom(input int cycles);
		logic [31:0] r;
		for (int c = 0; c < cycles; c++) begin
			r = randomWord();
			// About three strobes in four, so back-to-back runs are common.
			driveCycle(r[31:30] != 2'b00, 1'b0, randomSample());
		end
	endtask

	// Lets the last results come out before the run ends.
	task automatic drainResults();
		int count;
		count = 0;
		while (expectQ.size() != 0 && count < 8) begin
			@(posedge clock);
			#1;
			count++;
		end
		assert (expectQ.size() == 0)
			else failRun("[ERROR] results still pending after the last sample");
	endtask

	initial begin
		rst = 1'b1;
		loadData = 1'b0;
		stopLoad = 1'b0;
		dataIn = '0;
		clearHistory();
		repeat (2) @(posedge clock);
		#1;
		assert (!ready) else failValue("ready", 0, ready);
		assert (!outValid) else failValue("outValid", 0, outValid);
		rst = 1'b0;
		// One Idle cycle plus LENGTH load cycles.
		expectReadyAfter(LENGTH + 1);
		runImpulse();
		runRandom(200);

		// Stop together with a sample, which is still filtered.
		// The reload takes Stop, Idle and LENGTH load cycles after the strobe.
		driveCycle(1'b1, 1'b1, randomSample());
		assert (!ready) else failValue("ready", 0, ready);
		expectReadyAfter(LENGTH + 2);
		// The history is empty again, so the impulse shows the bare table.
		runImpulse();
		runRandom(150);

		// Stop on its own.
		driveCycle(1'b0, 1'b1, '0);
		assert (!ready) else failValue("ready", 0, ready);
		expectReadyAfter(LENGTH + 2);
		runRandom(100);
		drainResults();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/coeffRom.sv
`timescale 1ns/10ps
`default_nettype none

// Streams the first LENGTH entries of the coefficient table, one per cycle.
// The stream starts at entry 0 on the first enabled cycle.
// It restarts from entry 0 whenever enable has been low for a cycle.
module coeffRom #(
	parameter int LENGTH = 20,
	parameter int DATA_WIDTH = 8
) (
	input wire clock,
	input wire rst,
	input wire enable,
	output logic signed [DATA_WIDTH-1:0] coeffWord,
	output logic coeffLast
);

	// The index needs at least one bit, even for a single-tap filter.
	localparam int IDX_WIDTH = (LENGTH > 1) ? $clog2(LENGTH) : 1;
	localparam logic [IDX_WIDTH-1:0] LAST_IDX = IDX_WIDTH'(LENGTH - 1);

	// Table position of the word currently on coeffWord.
	logic [IDX_WIDTH-1:0] index;

	// The index steps once per enabled cycle.
	// It stops on the last entry, so it never points past the used part of the table.
	// Dropping enable sends it back to the start for the next load.
	always_ff @(posedge clock) begin
		if (rst) begin
			index <= '0;
		end else if (!enable) begin
			index <= '0;
		end else if (index != LAST_IDX) begin
			index <= index + 1'b1;
		end
	end

	// The table holds 8-bit words.
	// The size cast sign-extends or trims them to the sample width.
	assign coeffWord = DATA_WIDTH'(firTypesPkg::COEFF_TABLE[index]);

	// Flags the word that completes the load.
	// The controller leaves LoadCoeffs on this word.
	assign coeffLast = (index == LAST_IDX);

endmodule

`default_nettype wire

//--- hdl/firControl.sv
`timescale 1ns/10ps
`default_nettype none

// Sequencer of the FIR filter.
// It clears the history, loads the coefficients, runs the filter and stops on request.
// After a stop it goes round the same sequence again.
module firControl (
	input wire clock,
	input wire rst,
	input wire loadData,
	input wire stopLoad,
	input wire coeffLast,
	output logic coeffEnable,
	output firCtrlPkg::tapCtrlT coeffCtrl,
	output firCtrlPkg::tapCtrlT dataCtrl,
	output logic macStart,
	output logic ready
);

	firCtrlPkg::firStateT state;
	firCtrlPkg::firStateT stateNext;

	// High for a sample strobe that arrives while the filter runs.
	logic sampleTaken;

	// Idle lasts a single cycle.
	// LoadCoeffs lasts until the ROM flags its last word, which is LENGTH cycles.
	// A stop request in Run takes effect at the next edge, and Stop lasts one cycle.
	always_comb begin
		stateNext = state;
		case (state)
			firCtrlPkg::Idle: begin
				stateNext = firCtrlPkg::LoadCoeffs;
			end
			firCtrlPkg::LoadCoeffs: begin
				if (coeffLast) begin
					stateNext = firCtrlPkg::Run;
				end
			end
			firCtrlPkg::Run: begin
				if (stopLoad) begin
					stateNext = firCtrlPkg::Stop;
				end
			end
			default: begin
				stateNext = firCtrlPkg::Idle;
			end
		endcase
	end

	// Samples are only accepted in Run.
	// A strobe in the same cycle as a stop request is still filtered.
	assign sampleTaken = loadData && (state == firCtrlPkg::Run);

	// The ROM runs only while the coefficient line is being filled.
	assign coeffEnable = (state == firCtrlPkg::LoadCoeffs);

	// Both lines are emptied in Idle.
	// The coefficient line shifts on every load cycle.
	// The sample line shifts once for each accepted sample.
	always_comb begin
		coeffCtrl.clear = (state == firCtrlPkg::Idle);
		coeffCtrl.shift = (state == firCtrlPkg::LoadCoeffs);
		dataCtrl.clear = (state == firCtrlPkg::Idle);
		dataCtrl.shift = sampleTaken;
	end

	// ready is decoded from the next state, so it rises on the edge that enters Run.
	// It falls on the edge that leaves Run.
	// macStart trails the sample shift by one cycle, so the MAC sees the updated taps.
	always_ff @(posedge clock) begin
		if (rst) begin
			state <= firCtrlPkg::Idle;
			ready <= 1'b0;
			macStart <= 1'b0;
		end else begin
			state <= stateNext;
			ready <= (stateNext == firCtrlPkg::Run);
			macStart <= sampleTaken;
		end
	end

endmodule

`default_nettype wire

//--- hdl/firCtrlPkg.sv
`default_nettype none

// Sequencing definitions for the FIR controller and the tap lines it drives.
package firCtrlPkg;

	// Controller states.
	// Idle clears the history, LoadCoeffs fills the coefficient line,
	// Run filters samples and Stop ends a run before the next reload.
	typedef enum logic [1:0] {
		Idle       = 2'd0,
		LoadCoeffs = 2'd1,
		Run        = 2'd2,
		Stop       = 2'd3
	} firStateT;

	// Command for one tap line.
	// When both bits are set, clear wins over shift.
	typedef struct packed {
		logic shift;
		logic clear;
	} tapCtrlT;

endpackage

`default_nettype wire

//--- hdl/firFilter.sv
`timescale 1ns/10ps
`default_nettype none

// Direct-form FIR filter with a built-in coefficient table.
// After reset the coefficients are loaded, and then every accepted sample
// gives one full-precision result, one cycle later.
module firFilter #(
	parameter int LENGTH = 20,
	parameter int DATA_WIDTH = 8
) (
	input wire clock,
	input wire rst,
	input wire loadData,
	input wire stopLoad,
	input wire signed [DATA_WIDTH-1:0] dataIn,
	output logic ready,
	output logic outValid,
	output logic signed [firTypesPkg::accWidth(DATA_WIDTH, LENGTH)-1:0] dataOut
);

	// ROM stream into the coefficient line.
	logic coeffEnable;
	logic signed [DATA_WIDTH-1:0] coeffWord;
	logic coeffLast;

	// Commands for the two tap lines.
	firCtrlPkg::tapCtrlT coeffCtrl;
	firCtrlPkg::tapCtrlT dataCtrl;

	// All taps of both lines, in flat form.
	logic [LENGTH*DATA_WIDTH-1:0] coeffTaps;
	logic [LENGTH*DATA_WIDTH-1:0] dataTaps;

	logic macStart;

	firControl uControl (
		.clock       (clock),
		.rst         (rst),
		.loadData    (loadData),
		.stopLoad    (stopLoad),
		.coeffLast   (coeffLast),
		.coeffEnable (coeffEnable),
		.coeffCtrl   (coeffCtrl),
		.dataCtrl    (dataCtrl),
		.macStart    (macStart),
		.ready       (ready)
	);

	coeffRom #(.LENGTH(LENGTH), .DATA_WIDTH(DATA_WIDTH)) uCoeffRom (
		.clock     (clock),
		.rst       (rst),
		.enable    (coeffEnable),
		.coeffWord (coeffWord),
		.coeffLast (coeffLast)
	);

	// Coefficient line.
	// Entry 0 enters first and ends up on the oldest tap.
	tapLine #(.LENGTH(LENGTH), .DATA_WIDTH(DATA_WIDTH)) uCoeffLine (
		.clock (clock),
		.rst   (rst),
		.ctrl  (coeffCtrl),
		.din   (coeffWord),
		.taps  (coeffTaps)
	);

	// Sample history, newest sample on tap 0.
	tapLine #(.LENGTH(LENGTH), .DATA_WIDTH(DATA_WIDTH)) uDataLine (
		.clock (clock),
		.rst   (rst),
		.ctrl  (dataCtrl),
		.din   (dataIn),
		.taps  (dataTaps)
	);

	macSum #(.LENGTH(LENGTH), .DATA_WIDTH(DATA_WIDTH)) uMacSum (
		.clock     (clock),
		.rst       (rst),
		.start     (macStart),
		.coeffTaps (coeffTaps),
		.dataTaps  (dataTaps),
		.sum       (dataOut),
		.valid     (outValid)
	);

endmodule

`default_nettype wire

//--- hdl/firTypesPkg.sv
`default_nettype none

// Numeric definitions shared by the FIR datapath and its testbench model.
package firTypesPkg;

	// Largest number of taps the coefficient table can serve.
	localparam int MAX_TAPS = 32;

	// Built-in coefficient table, entry 0 first.
	// A filter with LENGTH taps reads entries 0 to LENGTH-1 only.
	// The pattern is deliberately not symmetric, so a reversed load order shows up.
	localparam logic signed [7:0] COEFF_TABLE [0:MAX_TAPS-1] = '{
		8'sd3,   -8'sd7,  8'sd12,  8'sd25, -8'sd18,  8'sd40,  8'sd66, -8'sd31,
		8'sd97,  8'sd127, -8'sd120, 8'sd54, -8'sd9,  8'sd21,  8'sd1,  -8'sd45,
		8'sd33,  -8'sd2,  8'sd14,  8'sd88, -8'sd60,  8'sd5,  -8'sd77,  8'sd19,
		8'sd46,  -8'sd11, 8'sd70, -8'sd24,  8'sd8,  -8'sd99,  8'sd37, -8'sd4
	};

	// Width of a full-precision sum of LENGTH products of two DATA_WIDTH words.
	// Each product needs twice the word width, and the sum grows by log2 of the tap count.
	function automatic int accWidth(input int dataWidth, input int length);
		return 2 * dataWidth + $clog2(length);
	endfunction

endpackage

`default_nettype wire

//--- hdl/macSum.sv
`timescale 1ns/10ps
`default_nettype none

// Multiply-accumulate stage of the direct-form filter.
// All LENGTH products are formed and summed in one combinational pass.
// The sum is then registered at full precision when start is high.
module macSum #(
	parameter int LENGTH = 20,
	parameter int DATA_WIDTH = 8
) (
	input wire clock,
	input wire rst,
	input wire start,
	input wire [LENGTH*DATA_WIDTH-1:0] coeffTaps,
	input wire [LENGTH*DATA_WIDTH-1:0] dataTaps,
	output logic signed [firTypesPkg::accWidth(DATA_WIDTH, LENGTH)-1:0] sum,
	output logic valid
);

	localparam int ACC_WIDTH = firTypesPkg::accWidth(DATA_WIDTH, LENGTH);

	// Combinational sum of the current tap contents.
	logic signed [ACC_WIDTH-1:0] sumNext;

	// Sample tap n holds x[k-n], with n = 0 the newest sample.
	// The coefficient line was filled in table order, so table entry n sits on tap LENGTH-1-n.
	// Pairing them this way gives the convolution sum of h[n] * x[k-n].
	always_comb begin : productSum
		logic signed [DATA_WIDTH-1:0] sampleWord;
		logic signed [DATA_WIDTH-1:0] coeffWord;
		logic signed [2*DATA_WIDTH-1:0] product;
		sumNext = '0;
		for (int n = 0; n < LENGTH; n++) begin
			sampleWord = dataTaps[n*DATA_WIDTH +: DATA_WIDTH];
			coeffWord = coeffTaps[(LENGTH-1-n)*DATA_WIDTH +: DATA_WIDTH];
			product = sampleWord * coeffWord;
			// Each product is sign-extended before it joins the sum.
			sumNext = sumNext + ACC_WIDTH'(product);
		end
	end

	// The result only moves on start, so it holds between valid pulses.
	// valid follows start by one cycle and marks the new result.
	always_ff @(posedge clock) begin
		if (rst) begin
			sum <= '0;
			valid <= 1'b0;
		end else begin
			valid <= start;
			if (start) begin
				sum <= sumNext;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/tapLine.sv
`timescale 1ns/10ps
`default_nettype none

// Delay line of LENGTH signed words with every tap visible at once.
// Tap 0 holds the newest word, and tap LENGTH-1 holds the oldest.
// Tap p sits at bits p*DATA_WIDTH and up in the flat taps bus.
module tapLine #(
	parameter int LENGTH = 20,
	parameter int DATA_WIDTH = 8
) (
	input wire clock,
	input wire rst,
	input wire firCtrlPkg::tapCtrlT ctrl,
	input wire signed [DATA_WIDTH-1:0] din,
	output logic [LENGTH*DATA_WIDTH-1:0] taps
);

	// One row per tap.
	logic [LENGTH-1:0][DATA_WIDTH-1:0] line;

	// Clear empties the whole line in one cycle and beats a shift in the same cycle.
	// A shift moves every word one tap older and takes din into tap 0.
	always_ff @(posedge clock) begin
		if (rst || ctrl.clear) begin
			line <= '0;
		end else if (ctrl.shift) begin
			for (int p = LENGTH - 1; p > 0; p--) begin
				line[p] <= line[p-1];
			end
			line[0] <= din;
		end
	end

	// The packed rows already lie in flat tap order.
	assign taps = line;

endmodule

`default_nettype wire

//--- src.f
+incdir+bench
hdl/firTypesPkg.sv
hdl/firCtrlPkg.sv
hdl/coeffRom.sv
hdl/tapLine.sv
hdl/macSum.sv
hdl/firControl.sv
hdl/firFilter.sv
bench/firFilterTb.sv
